/* src/rename_pkg.sv */
package rename_pkg;

    // architectural register file size, fixed by the isa
    localparam int ARCH_REGS = 32;

    typedef logic [4:0] arch_reg_t;   // x0..x31
    typedef logic [6:0] phys_tag_t;   // up to 128 physical registers
    typedef logic [6:0] opcode_t;     // rv32 major opcode field

    // major opcodes with special source / destination handling
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    // anything not listed above is treated as register-register

endpackage

/* src/register_alias_table.sv */
`timescale 1ns/10ps

module register_alias_table #(
    parameter int NUM_PHYS = 128
) (
    input  logic                  clk,
    input  logic                  reset,
    input  rename_pkg::arch_reg_t rs1,
    input  rename_pkg::arch_reg_t rs2,
    input  rename_pkg::arch_reg_t rd,
    input  logic                  alloc_en,
    input  rename_pkg::phys_tag_t new_tag,
    input  logic                  wb_en,
    input  rename_pkg::arch_reg_t wb_rd,
    input  rename_pkg::phys_tag_t wb_tag,
    output rename_pkg::phys_tag_t src1_map,
    output rename_pkg::phys_tag_t src2_map,
    output logic                  src1_valid,
    output logic                  src2_valid,
    output rename_pkg::phys_tag_t prev_tag
);

    import rename_pkg::*;

    phys_tag_t            map_table [ARCH_REGS];  // arch -> phys mapping
    logic [ARCH_REGS-1:0] ready_bits;             // value of current mapping produced
    logic                 wb_hit;

    // only a writeback of the live mapping wakes the register up
    assign wb_hit = wb_en && !ready_bits[wb_rd] && (map_table[wb_rd] == wb_tag);

    // lookups see the state before the update edge
    assign src1_map   = map_table[rs1];
    assign src2_map   = map_table[rs2];
    assign src1_valid = ready_bits[rs1];
    assign src2_valid = ready_bits[rs2];
    assign prev_tag   = map_table[rd];   // displaced tag, goes back to free list

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_table[i] <= phys_tag_t'(i);   // identity mapping
            end
            ready_bits <= '1;
        end else begin
            if (wb_hit) begin
                ready_bits[wb_rd] <= 1'b1;
            end
            // placed after the wakeup so a same-register rename clears the bit
            if (alloc_en) begin
                map_table[rd]  <= new_tag;
                ready_bits[rd] <= 1'b0;
            end
        end
    end

    // x0 is hardwired, stage must never allocate for it
    assert property (@(posedge clk) disable iff (reset)
        alloc_en |-> (rd != '0))
        else $error("rat: x0 remapped");

    // tag from free list must address a real physical register
    assert property (@(posedge clk) disable iff (reset)
        alloc_en |-> (int'(new_tag) < NUM_PHYS))
        else $error("rat: new_tag %0d out of range", new_tag);

endmodule

/* src/free_list.sv */
`timescale 1ns/10ps

module free_list #(
    parameter int NUM_PHYS = 128
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  alloc_en,
    input  rename_pkg::phys_tag_t ret_tag,
    output rename_pkg::phys_tag_t head_tag
);

    import rename_pkg::*;

    localparam int DEPTH   = NUM_PHYS - ARCH_REGS;              // tags not mapped at reset
    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    phys_tag_t          fifo_mem [DEPTH];
    logic [PTR_W-1:0]   head;       // next tag handed out
    logic [PTR_W-1:0]   tail;       // slot for the next returned tag
    logic [COUNT_W-1:0] count;      // free tags held
    logic               do_pop;
    logic               do_push;
    logic [PTR_W-1:0]   head_next;
    logic [PTR_W-1:0]   tail_next;

    assign do_pop  = alloc_en && (count != '0);
    assign do_push = alloc_en;      // every allocation returns the displaced tag

    assign head_tag = fifo_mem[head];

    // circular increment, depth need not be a power of two
    assign head_next = (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
    assign tail_next = (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                fifo_mem[i] <= phys_tag_t'(ARCH_REGS + i);   // tags 32 upward
            end
            head  <= '0;
            tail  <= '0;
            count <= COUNT_W'(DEPTH);    // starts full
        end else begin
            if (do_push) begin
                fifo_mem[tail] <= ret_tag;
                tail           <= tail_next;
            end
            if (do_pop) begin
                head <= head_next;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // both or neither
            endcase
        end
    end

    // pop and push are paired, so the queue never drains or overflows
    assert property (@(posedge clk) disable iff (reset)
        (count >= COUNT_W'(1)) && (count <= COUNT_W'(DEPTH)))
        else $error("free_list: occupancy %0d out of range", count);

endmodule

/* src/rename_stage.sv */
`timescale 1ns/10ps

module rename_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rename_req,
    input  rename_pkg::opcode_t   opcode,
    input  rename_pkg::arch_reg_t rs1,
    input  rename_pkg::arch_reg_t rs2,
    input  rename_pkg::arch_reg_t rd,
    input  rename_pkg::phys_tag_t src1_map,
    input  rename_pkg::phys_tag_t src2_map,
    input  logic                  src1_valid,
    input  logic                  src2_valid,
    input  rename_pkg::phys_tag_t prev_tag,
    input  rename_pkg::phys_tag_t head_tag,
    output logic                  alloc_en,
    output logic                  rename_done,
    output logic                  has_dest,
    output rename_pkg::phys_tag_t src1_tag,
    output rename_pkg::phys_tag_t src2_tag,
    output logic [1:0]            src_ready,
    output rename_pkg::phys_tag_t dest_tag,
    output rename_pkg::arch_reg_t dest_arch,
    output rename_pkg::phys_tag_t old_tag
);

    import rename_pkg::*;

    logic uses_rs1;
    logic uses_rs2;
    logic writes_rd;

    // opcode class decode
    always_comb begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        writes_rd = (rd != '0);        // x0 writes are dropped
        case (opcode)
            OPC_LUI, OPC_AUIPC, OPC_JAL: begin
                uses_rs1 = 1'b0;       // no register sources
                uses_rs2 = 1'b0;
            end
            OPC_LOAD, OPC_OP_IMM, OPC_JALR: begin
                uses_rs2 = 1'b0;       // rs1 + immediate
            end
            OPC_BRANCH, OPC_STORE: begin
                writes_rd = 1'b0;      // rd field is part of the immediate
            end
            default: begin
            end
        endcase
    end

    // table and free list update on the edge that samples the request
    assign alloc_en = rename_req && writes_rd;

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            rename_done <= 1'b0;
            has_dest    <= 1'b0;
        end else begin
            rename_done <= rename_req;     // single cycle pulse
            if (rename_req) begin
                has_dest <= writes_rd;
            end
        end
    end

    // payload, held until the next request
    always_ff @(posedge clk) begin
        if (rename_req) begin
            src1_tag     <= uses_rs1 ? src1_map : '0;
            src2_tag     <= uses_rs2 ? src2_map : '0;
            src_ready[0] <= uses_rs1 ? src1_valid : 1'b1;
            src_ready[1] <= uses_rs2 ? src2_valid : 1'b1;
            dest_tag     <= writes_rd ? head_tag : '0;
            old_tag      <= writes_rd ? prev_tag : '0;
            dest_arch    <= rd;
        end
    end

    // allocation only for a live request, and a free tag never equals the live one it replaces
    assert property (@(posedge clk) disable iff (reset)
        alloc_en |-> rename_req ##1 (dest_tag != old_tag))
        else $error("rename_stage: alloc_en without request or free tag still mapped");

endmodule

/* src/rename_top.sv */
`timescale 1ns/10ps

module rename_top #(
    parameter int NUM_PHYS = 128
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rename_req,
    input  rename_pkg::opcode_t   opcode,
    input  rename_pkg::arch_reg_t rs1,
    input  rename_pkg::arch_reg_t rs2,
    input  rename_pkg::arch_reg_t rd,
    input  logic                  wb_en,
    input  rename_pkg::arch_reg_t wb_rd,
    input  rename_pkg::phys_tag_t wb_tag,
    output logic                  rename_done,
    output logic                  has_dest,
    output rename_pkg::phys_tag_t src1_tag,
    output rename_pkg::phys_tag_t src2_tag,
    output logic [1:0]            src_ready,
    output rename_pkg::phys_tag_t dest_tag,
    output rename_pkg::arch_reg_t dest_arch,
    output rename_pkg::phys_tag_t old_tag
);

    import rename_pkg::*;

    logic      alloc_en;      // pop + push + table update
    phys_tag_t head_tag;      // next free tag
    phys_tag_t prev_tag;      // tag displaced by rd
    phys_tag_t src1_map;
    phys_tag_t src2_map;
    logic      src1_valid;
    logic      src2_valid;

    rename_stage u_stage (
        .clk        (clk),
        .reset      (reset),
        .rename_req (rename_req),
        .opcode     (opcode),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .src1_map   (src1_map),
        .src2_map   (src2_map),
        .src1_valid (src1_valid),
        .src2_valid (src2_valid),
        .prev_tag   (prev_tag),
        .head_tag   (head_tag),
        .alloc_en   (alloc_en),
        .rename_done(rename_done),
        .has_dest   (has_dest),
        .src1_tag   (src1_tag),
        .src2_tag   (src2_tag),
        .src_ready  (src_ready),
        .dest_tag   (dest_tag),
        .dest_arch  (dest_arch),
        .old_tag    (old_tag)
    );

    register_alias_table #(
        .NUM_PHYS(NUM_PHYS)
    ) u_rat (
        .clk       (clk),
        .reset     (reset),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .alloc_en  (alloc_en),
        .new_tag   (head_tag),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_tag    (wb_tag),
        .src1_map  (src1_map),
        .src2_map  (src2_map),
        .src1_valid(src1_valid),
        .src2_valid(src2_valid),
        .prev_tag  (prev_tag)
    );

    free_list #(
        .NUM_PHYS(NUM_PHYS)
    ) u_free_list (
        .clk     (clk),
        .reset   (reset),
        .alloc_en(alloc_en),
        .ret_tag (prev_tag),   // old mapping recycled immediately
        .head_tag(head_tag)
    );

endmodule

/* sim/tb_rename.sv */
`timescale 1ns/10ps

module tb_rename;

    import rename_pkg::*;

    localparam int      NUM_PHYS   = 128;
    localparam int      CLK_PERIOD = 4;
    localparam int      TOTAL_OPS  = 600;           // reset cycles + renames + writebacks, rounded up
    localparam opcode_t OPC_OP     = 7'b0110011;    // register-register

    logic       clk;
    logic       reset;
    logic       rename_req;
    opcode_t    opcode;
    arch_reg_t  rs1;
    arch_reg_t  rs2;
    arch_reg_t  rd;
    logic       wb_en;
    arch_reg_t  wb_rd;
    phys_tag_t  wb_tag;
    logic       rename_done;
    logic       has_dest;
    phys_tag_t  src1_tag;
    phys_tag_t  src2_tag;
    logic [1:0] src_ready;
    phys_tag_t  dest_tag;
    arch_reg_t  dest_arch;
    phys_tag_t  old_tag;

    phys_tag_t   model_map [32];    // reference copy of the alias table
    bit          model_rdy [32];
    phys_tag_t   free_q [$];        // reference free list, head at index 0
    int          total_allocs;
    int unsigned lcg_state = 24306;

    rename_top #(
        .NUM_PHYS(NUM_PHYS)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .rename_req (rename_req),
        .opcode     (opcode),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_tag     (wb_tag),
        .rename_done(rename_done),
        .has_dest   (has_dest),
        .src1_tag   (src1_tag),
        .src2_tag   (src2_tag),
        .src_ready  (src_ready),
        .dest_tag   (dest_tag),
        .dest_arch  (dest_arch),
        .old_tag    (old_tag)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;     // upper bits, low ones cycle too fast
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0d ns: %s: got %0d, expected %0d", $time, what, got, exp);
            abort_run("value mismatch");
        end
    endtask

    // source usage and destination write per opcode class
    function automatic void classify_opcode(input opcode_t op, input arch_reg_t rdst,
                                            output bit u1, output bit u2, output bit wr);
        u1 = 1'b1;
        u2 = 1'b1;
        wr = (rdst != 0);
        if (op == OPC_LUI || op == OPC_AUIPC || op == OPC_JAL) begin
            u1 = 1'b0;
            u2 = 1'b0;
        end else if (op == OPC_LOAD || op == OPC_OP_IMM || op == OPC_JALR) begin
            u2 = 1'b0;
        end else if (op == OPC_BRANCH || op == OPC_STORE) begin
            wr = 1'b0;
        end
    endfunction

    task automatic reset_model();
        for (int i = 0; i < 32; i++) begin
            model_map[i] = phys_tag_t'(i);
            model_rdy[i] = 1'b1;
        end
        free_q.delete();
        for (int t = 32; t < NUM_PHYS; t++) begin
            free_q.push_back(phys_tag_t'(t));
        end
        total_allocs = 0;
    endtask

    task automatic do_rename(input opcode_t op, input arch_reg_t r1, input arch_reg_t r2,
                             input arch_reg_t rdst);
        bit         u1;
        bit         u2;
        bit         wr;
        phys_tag_t  exp_s1;
        phys_tag_t  exp_s2;
        phys_tag_t  exp_dest;
        phys_tag_t  exp_old;
        logic [1:0] exp_rdy;
        int         waited;
        classify_opcode(op, rdst, u1, u2, wr);
        exp_s1     = u1 ? model_map[r1] : '0;
        exp_s2     = u2 ? model_map[r2] : '0;
        exp_rdy[0] = u1 ? model_rdy[r1] : 1'b1;
        exp_rdy[1] = u2 ? model_rdy[r2] : 1'b1;
        exp_dest   = wr ? free_q[0] : '0;
        exp_old    = wr ? model_map[rdst] : '0;
        @(posedge clk);
        rename_req <= 1'b1;
        opcode     <= op;
        rs1        <= r1;
        rs2        <= r2;
        rd         <= rdst;
        @(posedge clk);
        rename_req <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!rename_done && waited < 8);
        if (!rename_done) begin
            abort_run("rename_done did not rise after a rename request");
        end else begin
            check_eq(waited, 1, "rename_done latency");
            check_eq(src1_tag, exp_s1, "src1_tag");
            check_eq(src2_tag, exp_s2, "src2_tag");
            check_eq(src_ready, exp_rdy, "src_ready");
            check_eq(has_dest, wr, "has_dest");
            check_eq(dest_tag, exp_dest, "dest_tag");
            check_eq(old_tag, exp_old, "old_tag");
            check_eq(dest_arch, rdst, "dest_arch");
            if (wr) begin
                void'(free_q.pop_front());
                free_q.push_back(model_map[rdst]);   // displaced tag returns at once
                model_map[rdst] = exp_dest;
                model_rdy[rdst] = 1'b0;
                total_allocs++;
            end
            @(negedge clk);
            check_eq(rename_done, 1'b0, "rename_done pulse width");
        end
    endtask

    task automatic do_writeback(input arch_reg_t r, input phys_tag_t tag);
        @(posedge clk);
        wb_en  <= 1'b1;
        wb_rd  <= r;
        wb_tag <= tag;
        @(posedge clk);
        wb_en <= 1'b0;
        if (!model_rdy[r] && model_map[r] == tag) begin
            model_rdy[r] = 1'b1;                 // stale tags are dropped
        end
    endtask

    task automatic verify_reset_state();
        @(negedge clk);
        check_eq(rename_done, 1'b0, "rename_done after reset");
        check_eq(has_dest, 1'b0, "has_dest after reset");
        for (int i = 1; i < 32; i++) begin
            do_rename(OPC_OP, arch_reg_t'(i), arch_reg_t'(i), 5'd0);
            check_eq(src1_tag, i, "identity map src1");
            check_eq(src2_tag, i, "identity map src2");
            check_eq(src_ready, 2'b11, "ready after reset");
        end
        do_rename(OPC_OP, 5'd1, 5'd2, 5'd7);
        check_eq(dest_tag, 32, "first free tag");
        check_eq(old_tag, 7, "old tag is arch index");
    endtask

    task automatic exercise_alloc_order();
        do_rename(OPC_OP, 5'd4, 5'd5, 5'd1);
        check_eq(dest_tag, 33, "second allocation");
        do_rename(OPC_OP, 5'd2, 5'd6, 5'd2);     // rs1 == rd
        check_eq(src1_tag, 2, "source sees previous mapping");
        check_eq(dest_tag, 34, "third allocation");
        do_rename(OPC_OP, 5'd1, 5'd3, 5'd3);
        check_eq(src1_tag, 33, "x1 renamed earlier");
        check_eq(src_ready, 2'b10, "x1 pending, x3 ready");
        check_eq(dest_tag, 35, "fourth allocation");
    endtask

    task automatic probe_wakeup();
        do_rename(OPC_OP, 5'd0, 5'd0, 5'd5);
        check_eq(dest_tag, 36, "x5 new tag");
        do_rename(OPC_OP, 5'd5, 5'd0, 5'd0);
        check_eq(src1_tag, 36, "x5 lookup");
        check_eq(src_ready[0], 1'b0, "x5 pending");
        do_writeback(5'd5, 7'd5);                // old tag, stale
        do_rename(OPC_OP, 5'd5, 5'd0, 5'd0);
        check_eq(src_ready[0], 1'b0, "stale writeback ignored");
        do_writeback(5'd5, 7'd36);
        do_rename(OPC_OP, 5'd5, 5'd0, 5'd0);
        check_eq(src_ready[0], 1'b1, "matching writeback wakes x5");
    endtask

    task automatic sweep_opcode_classes();
        do_rename(OPC_LUI, 5'd3, 5'd4, 5'd8);
        check_eq(src_ready, 2'b11, "lui ready");
        check_eq(dest_tag, 37, "lui dest");
        do_rename(OPC_AUIPC, 5'd3, 5'd4, 5'd9);
        check_eq(src1_tag, 0, "auipc src1");
        do_rename(OPC_JAL, 5'd3, 5'd4, 5'd10);
        check_eq(src2_tag, 0, "jal src2");
        do_rename(OPC_OP_IMM, 5'd1, 5'd2, 5'd11);
        check_eq(src2_tag, 0, "op-imm src2");
        check_eq(src_ready[1], 1'b1, "op-imm src2 ready");
        do_rename(OPC_LOAD, 5'd9, 5'd2, 5'd12);
        check_eq(src1_tag, 38, "load base from auipc");
        do_rename(OPC_JALR, 5'd4, 5'd2, 5'd13);
        check_eq(dest_tag, 42, "jalr dest");
        do_rename(OPC_BRANCH, 5'd1, 5'd2, 5'd14);
        check_eq(has_dest, 1'b0, "branch has no dest");
        do_rename(OPC_STORE, 5'd1, 5'd2, 5'd15);
        check_eq(has_dest, 1'b0, "store has no dest");
        do_rename(OPC_OP, 5'd1, 5'd2, 5'd0);
        check_eq(has_dest, 1'b0, "x0 has no dest");
        do_rename(OPC_OP, 5'd1, 5'd2, 5'd15);
        check_eq(dest_tag, 43, "sequence continues");
    endtask

    task automatic stress_recycling();
        opcode_t   op_list [9];
        arch_reg_t r;
        phys_tag_t tag;
        op_list = '{OPC_OP, OPC_LOAD, OPC_OP_IMM, OPC_JALR, OPC_LUI,
                    OPC_AUIPC, OPC_JAL, OPC_BRANCH, OPC_STORE};
        for (int n = 0; n < 200; n++) begin
            do_rename(op_list[lcg_next() % 9], arch_reg_t'(lcg_next() % 32),
                      arch_reg_t'(lcg_next() % 32), arch_reg_t'(lcg_next() % 32));
            if (lcg_next() % 2 == 0) begin
                r = arch_reg_t'(lcg_next() % 32);
                if (lcg_next() % 4 != 0) begin
                    tag = model_map[r];
                end else begin
                    tag = phys_tag_t'(lcg_next() % NUM_PHYS);   // mostly stale
                end
                do_writeback(r, tag);
            end
        end
        check_eq(total_allocs > NUM_PHYS - 32, 1'b1, "fresh tags exhausted");
    endtask

    // watchdog
    initial begin
        #(TOTAL_OPS * CLK_PERIOD * 4);
        abort_run("watchdog expired, simulation ran too long");
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        rename_req = 1'b0;
        opcode     = '0;
        rs1        = '0;
        rs2        = '0;
        rd         = '0;
        wb_en      = 1'b0;
        wb_rd      = '0;
        wb_tag     = '0;
        reset_model();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        verify_reset_state();
        exercise_alloc_order();
        probe_wakeup();
        sweep_opcode_classes();
        stress_recycling();
        $display("TEST OK");
        $finish;
    end

endmodule

/* filelist.f */
src/rename_pkg.sv
src/register_alias_table.sv
src/free_list.sv
src/rename_stage.sv
src/rename_top.sv
sim/tb_rename.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_rename \
    --Mdir obj_dir -o tb_rename

sim_out=$(./obj_dir/tb_rename 2>&1) || true
echo "$sim_out"

if grep -qx "TEST OK" <<< "$sim_out"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
